//--- common/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// integer data path width
`define XLEN 32

// multiplier pipeline depth, start to done
`define MUL_LAT 3

// restoring divider steps, one per clock
`define DIV_ITERS 32

`endif

//--- common/alu_op_pkg.sv
package alu_op_pkg;

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_ADD   = 8'h01,
        OP_ADDU  = 8'h02,
        OP_SUB   = 8'h03,
        OP_SUBU  = 8'h04,
        OP_AND   = 8'h05,
        OP_OR    = 8'h06,
        OP_XOR   = 8'h07,
        OP_NOR   = 8'h08,
        OP_SLT   = 8'h09,
        OP_SLTU  = 8'h0a,
        OP_SLL   = 8'h0b,
        OP_SRL   = 8'h0c,
        OP_SRA   = 8'h0d,
        OP_LUI   = 8'h0e,
        OP_TEQ   = 8'h10,
        OP_TNE   = 8'h11,
        OP_MFHI  = 8'h20,
        OP_MFLO  = 8'h21,
        OP_MTHI  = 8'h22,
        OP_MTLO  = 8'h23,
        OP_MULT  = 8'h30,
        OP_MULTU = 8'h31,
        OP_MUL   = 8'h32,
        OP_DIV   = 8'h33,
        OP_DIVU  = 8'h34,
        OP_MADD  = 8'h35,
        OP_MADDU = 8'h36,
        OP_MSUB  = 8'h37,
        OP_MSUBU = 8'h38
    } alu_op_e;

    // multiply/divide ops whose result lands in HI/LO
    function automatic logic is_hilo_md(alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
                          OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    // multiply that writes a GPR instead
    function automatic logic is_mul_gpr(alu_op_e op);
        return op == OP_MUL;
    endfunction

endpackage

//--- common/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;
    import alu_op_pkg::*;

    // one lane's issue slot
    typedef struct packed {
        alu_op_e          op;
        logic [`XLEN-1:0] src_a;
        logic [`XLEN-1:0] src_b;
    } lane_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic             overflow;
        logic             trap;
    } lane_res_t;

    // shared by multiplier and divider
    typedef struct packed {
        logic             start_mul;
        logic             start_div;
        logic             is_signed;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
    } md_cmd_t;

endpackage

//--- rtl/alu_lane.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_lane
    import alu_op_pkg::*, exec_pkg::*;
(
    input  lane_req_t          req_i,
    input  logic [2*`XLEN-1:0] hilo_i,
    output lane_res_t          res_o
);

    localparam int SH_W = $clog2(`XLEN);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;
    logic [SH_W-1:0]  shamt;
    logic             lt_s;
    logic             lt_u;

    assign a     = req_i.src_a;
    assign b     = req_i.src_b;
    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[SH_W-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        res_o = '0;
        case (req_i.op)
            OP_ADD, OP_ADDU: res_o.result = sum;
            OP_SUB, OP_SUBU: res_o.result = diff;
            OP_AND:          res_o.result = a & b;
            OP_OR:           res_o.result = a | b;
            OP_XOR:          res_o.result = a ^ b;
            OP_NOR:          res_o.result = ~(a | b);
            OP_SLT:          res_o.result = `XLEN'(lt_s);
            OP_SLTU:         res_o.result = `XLEN'(lt_u);
            OP_SLL:          res_o.result = b << shamt;
            OP_SRL:          res_o.result = b >> shamt;
            OP_SRA:          res_o.result = $signed(b) >>> shamt;
            OP_LUI:          res_o.result = b << 16;
            OP_MFHI:         res_o.result = hilo_i[2*`XLEN-1:`XLEN];
            OP_MFLO:         res_o.result = hilo_i[`XLEN-1:0];
            default:         res_o.result = '0;
        endcase

        // signed overflow only for the trapping forms
        if (req_i.op == OP_ADD) begin
            res_o.overflow = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
        end else if (req_i.op == OP_SUB) begin
            res_o.overflow = (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]);
        end

        res_o.trap = ((req_i.op == OP_TEQ) && (a == b)) ||
                     ((req_i.op == OP_TNE) && (a != b));
    end

endmodule

//--- muldiv/mul_pipe.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module mul_pipe
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  md_cmd_t            cmd_i,
    output logic               done_o,
    output logic [2*`XLEN-1:0] prod_o
);

    logic signed [`XLEN:0]     a_ext;
    logic signed [`XLEN:0]     b_ext;
    logic signed [2*`XLEN-1:0] full;
    logic [2*`XLEN-1:0]        prod_q [`MUL_LAT];
    logic [`MUL_LAT-1:0]       valid_q;

    // one extra bit makes a single signed multiply cover both forms
    assign a_ext = {cmd_i.is_signed & cmd_i.a[`XLEN-1], cmd_i.a};
    assign b_ext = {cmd_i.is_signed & cmd_i.b[`XLEN-1], cmd_i.b};
    assign full  = a_ext * b_ext;

    always_ff @(posedge clk) begin
        prod_q[0] <= full;
        for (int i = 1; i < `MUL_LAT; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`MUL_LAT-2:0], cmd_i.start_mul};
        end
    end

    assign done_o = valid_q[`MUL_LAT-1];
    assign prod_o = prod_q[`MUL_LAT-1];

endmodule

//--- muldiv/div_iter.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module div_iter
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  md_cmd_t            cmd_i,
    output logic               busy_o,
    output logic               done_o,
    output logic [2*`XLEN-1:0] rem_quot_o
);

    localparam int CNT_W = $clog2(`DIV_ITERS);

    logic [`XLEN-1:0] a_abs;
    logic [`XLEN-1:0] b_abs;
    logic [`XLEN-1:0] rem_q;
    logic [`XLEN-1:0] quot_q;
    logic [`XLEN-1:0] dvsr_q;
    logic             quot_neg_q;
    logic             rem_neg_q;
    logic [`XLEN:0]   shifted;
    logic [`XLEN:0]   trial;
    logic             fits;
    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    logic             done_q;

    assign a_abs = (cmd_i.is_signed && cmd_i.a[`XLEN-1]) ? -cmd_i.a : cmd_i.a;
    assign b_abs = (cmd_i.is_signed && cmd_i.b[`XLEN-1]) ? -cmd_i.b : cmd_i.b;

    // restoring step, next dividend bit shifted in from the quotient
    assign shifted = {rem_q, quot_q[`XLEN-1]};
    assign trial   = shifted - {1'b0, dvsr_q};
    assign fits    = shifted >= {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cmd_i.start_div) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`DIV_ITERS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i.start_div) begin
            rem_q      <= '0;
            quot_q     <= a_abs;
            dvsr_q     <= b_abs;
            quot_neg_q <= cmd_i.is_signed & (cmd_i.a[`XLEN-1] ^ cmd_i.b[`XLEN-1]);
            rem_neg_q  <= cmd_i.is_signed & cmd_i.a[`XLEN-1];
        end else if (busy_q) begin
            rem_q  <= fits ? trial[`XLEN-1:0] : shifted[`XLEN-1:0];
            quot_q <= {quot_q[`XLEN-2:0], fits};
        end
    end

    // truncate toward zero, remainder follows the dividend
    assign rem_quot_o = {rem_neg_q ? -rem_q : rem_q, quot_neg_q ? -quot_q : quot_q};
    assign busy_o     = busy_q;
    assign done_o     = done_q;

endmodule

//--- muldiv/muldiv_ctrl.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module muldiv_ctrl
    import alu_op_pkg::*, exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               flush_exc_i,
    input  lane_req_t          req1_i,
    input  lane_req_t          req2_i,
    input  logic               mul_done_i,
    input  logic [2*`XLEN-1:0] prod_i,
    input  logic               div_done_i,
    input  logic               div_busy_i,
    input  logic [2*`XLEN-1:0] rem_quot_i,
    output md_cmd_t            cmd_o,
    output logic               stall_o,
    output logic [2*`XLEN-1:0] hilo_o,
    output logic [`XLEN-1:0]   mul_lo_o
);

    lane_req_t          sel_req;
    logic               lane2_md;
    logic               md_present;
    logic               sel_is_div;
    logic               sel_signed;
    logic               start;
    logic               unit_done;
    logic               issued_q;
    logic               hilo_writer;
    logic               hilo_we;
    logic [2*`XLEN-1:0] md_val;
    logic [`XLEN-1:0]   hi_d;
    logic [`XLEN-1:0]   lo_d;
    logic [2*`XLEN-1:0] hilo_q;

    // lane 2 gets the unit when it carries a mul/div
    assign lane2_md   = is_hilo_md(req2_i.op) | is_mul_gpr(req2_i.op);
    assign sel_req    = lane2_md ? req2_i : req1_i;
    assign md_present = is_hilo_md(sel_req.op) | is_mul_gpr(sel_req.op);
    assign sel_is_div = sel_req.op inside {OP_DIV, OP_DIVU};

    always_comb begin
        case (sel_req.op)
            OP_MULT, OP_MUL, OP_DIV, OP_MADD, OP_MSUB: sel_signed = 1'b1;
            default:                                   sel_signed = 1'b0;
        endcase
    end

    assign unit_done = sel_is_div ? div_done_i : mul_done_i;
    assign start     = md_present & ~issued_q & ~flush_i;
    assign stall_o   = md_present & ~unit_done & ~flush_i;

    always_comb begin
        cmd_o.start_mul = start & ~sel_is_div;
        cmd_o.start_div = start & sel_is_div & ~div_busy_i;
        cmd_o.is_signed = sel_signed;
        cmd_o.a         = sel_req.src_a;
        cmd_o.b         = sel_req.src_b;
    end

    // one start per operation, cleared when it retires
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issued_q <= 1'b0;
        end else if (flush_i) begin
            issued_q <= 1'b0;
        end else if (cmd_o.start_mul || cmd_o.start_div) begin
            issued_q <= 1'b1;
        end else if (unit_done) begin
            issued_q <= 1'b0;
        end
    end

    always_comb begin
        case (sel_req.op)
            OP_MULT, OP_MULTU: md_val = prod_i;
            OP_DIV, OP_DIVU:   md_val = rem_quot_i;
            OP_MADD, OP_MADDU: md_val = hilo_q + prod_i;
            OP_MSUB, OP_MSUBU: md_val = hilo_q - prod_i;
            default:           md_val = hilo_q;
        endcase
    end

    // lane 2 wins on a shared half
    assign hi_d = (req2_i.op == OP_MTHI)   ? req2_i.src_a :
                  is_hilo_md(req2_i.op)    ? md_val[2*`XLEN-1:`XLEN] :
                  (req1_i.op == OP_MTHI)   ? req1_i.src_a :
                                             md_val[2*`XLEN-1:`XLEN];
    assign lo_d = (req2_i.op == OP_MTLO)   ? req2_i.src_a :
                  is_hilo_md(req2_i.op)    ? md_val[`XLEN-1:0] :
                  (req1_i.op == OP_MTLO)   ? req1_i.src_a :
                                             md_val[`XLEN-1:0];

    assign hilo_writer = is_hilo_md(sel_req.op) ||
                         (req1_i.op inside {OP_MTHI, OP_MTLO}) ||
                         (req2_i.op inside {OP_MTHI, OP_MTLO});
    assign hilo_we = hilo_writer & ~stall_o & ~flush_i & ~flush_exc_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= {hi_d, lo_d};
        end
    end

    assign hilo_o   = hilo_q;
    assign mul_lo_o = prod_i[`XLEN-1:0];

endmodule

//--- rtl/dual_exec.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module dual_exec
    import alu_op_pkg::*, exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      flush_exc_i,
    input  lane_req_t req1_i,
    input  lane_req_t req2_i,
    output lane_res_t res1_o,
    output lane_res_t res2_o,
    output logic      stall_o
);

    lane_res_t          alu1_res;
    lane_res_t          alu2_res;
    md_cmd_t            md_cmd;
    logic [2*`XLEN-1:0] hilo;
    logic [2*`XLEN-1:0] prod;
    logic [2*`XLEN-1:0] rem_quot;
    logic [`XLEN-1:0]   mul_lo;
    logic               mul_done;
    logic               div_done;
    logic               div_busy;

    alu_lane u_alu1 (
        .req_i  (req1_i),
        .hilo_i (hilo),
        .res_o  (alu1_res)
    );

    alu_lane u_alu2 (
        .req_i  (req2_i),
        .hilo_i (hilo),
        .res_o  (alu2_res)
    );

    muldiv_ctrl u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .flush_exc_i (flush_exc_i),
        .req1_i      (req1_i),
        .req2_i      (req2_i),
        .mul_done_i  (mul_done),
        .prod_i      (prod),
        .div_done_i  (div_done),
        .div_busy_i  (div_busy),
        .rem_quot_i  (rem_quot),
        .cmd_o       (md_cmd),
        .stall_o     (stall_o),
        .hilo_o      (hilo),
        .mul_lo_o    (mul_lo)
    );

    mul_pipe u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .cmd_i   (md_cmd),
        .done_o  (mul_done),
        .prod_o  (prod)
    );

    div_iter u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .cmd_i      (md_cmd),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .rem_quot_o (rem_quot)
    );

    // MUL result comes back from the shared multiplier
    always_comb begin
        res1_o = alu1_res;
        res2_o = alu2_res;
        if (is_mul_gpr(req1_i.op)) begin
            res1_o.result = mul_lo;
        end
        if (is_mul_gpr(req2_i.op)) begin
            res2_o.result = mul_lo;
        end
    end

endmodule

//--- sim/dual_exec_checker.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module dual_exec_checker
    import alu_op_pkg::*, exec_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input lane_req_t req1_i,
    input lane_req_t req2_i,
    input md_cmd_t   cmd_o,
    input logic      stall_o,
    input logic      div_busy_i,
    input logic      mul_done_i,
    input logic      div_done_i
);

    logic md_present;

    assign md_present = is_hilo_md(req1_i.op) || is_mul_gpr(req1_i.op) ||
                        is_hilo_md(req2_i.op) || is_mul_gpr(req2_i.op);

    // a stall begins only together with a start command
    stall_needs_md: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> md_present && (cmd_o.start_mul || cmd_o.start_div || $past(stall_o)))
        else $error("stall_o high with no multiply/divide started");

    no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_busy_i |-> !(cmd_o.start_mul || cmd_o.start_div))
        else $error("unit started while the divider is busy");

    // done pulses trace back to their start cycle
    mul_done_has_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_done_i |-> $past(cmd_o.start_mul, `MUL_LAT))
        else $error("multiplier done without a start");

    div_done_has_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_done_i |-> $past(cmd_o.start_div, `DIV_ITERS + 1))
        else $error("divider done without a start");

endmodule

//--- sim/dual_exec_tb.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module dual_exec_tb
    import alu_op_pkg::*, exec_pkg::*;
();

    localparam int STALL_TIMEOUT = 100;

    logic        clk;
    logic        rst_n_i;
    logic        flush_i;
    logic        flush_exc_i;
    lane_req_t   req1_i;
    lane_req_t   req2_i;
    lane_res_t   res1_o;
    lane_res_t   res2_o;
    logic        stall_o;
    logic [31:0] lcg_q;
    logic [63:0] model_hilo;
    int          check_count;
    int          err_count;
    int          test_errs;

    alu_op_e alu_ops [17] = '{OP_NOP, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR,
                              OP_XOR, OP_NOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
                              OP_LUI, OP_TEQ, OP_TNE};
    alu_op_e mul_ops [7]  = '{OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};

    dual_exec uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .flush_exc_i (flush_exc_i),
        .req1_i      (req1_i),
        .req2_i      (req2_i),
        .res1_o      (res1_o),
        .res2_o      (res2_o),
        .stall_o     (stall_o)
    );

    bind muldiv_ctrl dual_exec_checker u_checker (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req1_i     (req1_i),
        .req2_i     (req2_i),
        .cmd_o      (cmd_o),
        .stall_o    (stall_o),
        .div_busy_i (div_busy_i),
        .mul_done_i (mul_done_i),
        .div_done_i (div_done_i)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
        return lcg_q ^ (lcg_q >> 15);
    endfunction

    function automatic alu_op_e rand_alu_op();
        return alu_ops[next_rand() % 17];
    endfunction

    task automatic check_val(input string sig, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0t: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Something failed");
        $finish;
    endtask

    function automatic lane_res_t model_alu(lane_req_t r, logic [63:0] hl);
        lane_res_t m;
        longint    sa;
        longint    sb;
        longint    s;
        m  = '0;
        sa = $signed(r.src_a);
        sb = $signed(r.src_b);
        s  = 0;
        case (r.op)
            OP_ADD, OP_ADDU: s = sa + sb;
            OP_SUB, OP_SUBU: s = sa - sb;
            OP_AND:  m.result = r.src_a & r.src_b;
            OP_OR:   m.result = r.src_a | r.src_b;
            OP_XOR:  m.result = r.src_a ^ r.src_b;
            OP_NOR:  m.result = ~(r.src_a | r.src_b);
            OP_SLT:  m.result = 32'(sa < sb);
            OP_SLTU: m.result = 32'(r.src_a < r.src_b);
            OP_SLL:  m.result = r.src_b << r.src_a[4:0];
            OP_SRL:  m.result = r.src_b >> r.src_a[4:0];
            OP_SRA:  m.result = 32'(sb >>> r.src_a[4:0]);
            OP_LUI:  m.result = {r.src_b[15:0], 16'h0000};
            OP_TEQ:  m.trap = (r.src_a == r.src_b);
            OP_TNE:  m.trap = (r.src_a != r.src_b);
            OP_MFHI: m.result = hl[63:32];
            OP_MFLO: m.result = hl[31:0];
            OP_MUL:  m.result = r.src_a * r.src_b;
            default: m.result = '0;
        endcase
        if (r.op inside {OP_ADD, OP_ADDU, OP_SUB, OP_SUBU}) begin
            m.result = s[31:0];
        end
        // exact sum no longer fits in 32 signed bits
        if (r.op inside {OP_ADD, OP_SUB}) begin
            m.overflow = (s != longint'($signed(s[31:0])));
        end
        return m;
    endfunction

    function automatic logic [63:0] model_md(lane_req_t r, logic [63:0] hl);
        longint      sa;
        longint      sb;
        logic [63:0] ps;
        logic [63:0] pu;
        sa = $signed(r.src_a);
        sb = $signed(r.src_b);
        ps = sa * sb;
        pu = {32'h0, r.src_a} * {32'h0, r.src_b};
        case (r.op)
            OP_MULT:  return ps;
            OP_MULTU: return pu;
            OP_MADD:  return hl + ps;
            OP_MADDU: return hl + pu;
            OP_MSUB:  return hl - ps;
            OP_MSUBU: return hl - pu;
            OP_DIV:   return {32'(sa % sb), 32'(sa / sb)};
            OP_DIVU:  return {r.src_a % r.src_b, r.src_a / r.src_b};
            default:  return hl;
        endcase
    endfunction

    // unit results always start from the old HI/LO
    function automatic logic [63:0] apply_lane(logic [63:0] hl, logic [63:0] old, lane_req_t r);
        if (is_hilo_md(r.op)) begin
            hl = model_md(r, old);
        end else if (r.op == OP_MTHI) begin
            hl[63:32] = r.src_a;
        end else if (r.op == OP_MTLO) begin
            hl[31:0] = r.src_a;
        end
        return hl;
    endfunction

    task automatic run_pair(input alu_op_e op1, input logic [31:0] a1, input logic [31:0] b1,
                            input alu_op_e op2, input logic [31:0] a2, input logic [31:0] b2,
                            input logic exc);
        lane_req_t   r1;
        lane_req_t   r2;
        logic [63:0] hl;
        int          cycles;
        int          exp_cycles;
        r1 = '{op1, a1, b1};
        r2 = '{op2, a2, b2};
        exp_cycles = 0;
        if (is_hilo_md(op1) || is_mul_gpr(op1) || is_hilo_md(op2) || is_mul_gpr(op2)) begin
            exp_cycles = ((op1 inside {OP_DIV, OP_DIVU}) || (op2 inside {OP_DIV, OP_DIVU})) ?
                         `DIV_ITERS + 1 : `MUL_LAT;
        end
        @(posedge clk);
        req1_i      <= r1;
        req2_i      <= r2;
        flush_exc_i <= exc;
        cycles = 0;
        @(negedge clk);
        while (stall_o && cycles < STALL_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (stall_o) begin
            stop_on_timeout("stall_o stayed high on a multiply/divide pair");
        end else begin
            check_val("stall cycles", cycles, exp_cycles);
            check_val("res1_o", res1_o, model_alu(r1, model_hilo));
            check_val("res2_o", res2_o, model_alu(r2, model_hilo));
            hl = apply_lane(apply_lane(model_hilo, model_hilo, r1), model_hilo, r2);
            if (!exc) begin
                model_hilo = hl;
            end
        end
    endtask

    task automatic read_hilo();
        run_pair(OP_MFHI, '0, '0, OP_MFLO, '0, '0, 1'b0);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic test_alu();
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        read_hilo();
        for (int i = 0; i < 200; i++) begin
            op = rand_alu_op();
            a  = next_rand();
            b  = (next_rand() % 4 == 0) ? a : next_rand();
            run_pair(op, a, b, rand_alu_op(), next_rand(), next_rand(), 1'b0);
        end
        end_test("alu pairs");
    endtask

    task automatic test_md(input string name, input logic is_div, input int count);
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < count; i++) begin
            op = mul_ops[next_rand() % 7];
            if (is_div) begin
                op = (next_rand() % 2) ? OP_DIV : OP_DIVU;
            end
            a = next_rand();
            b = next_rand();
            // small divisors now and then with the sign kept
            if (is_div && (next_rand() % 2)) begin
                b = $signed(b) >>> 20;
            end
            if (b == '0) begin
                b = 32'd3;
            end
            if (next_rand() % 2) begin
                run_pair(op, a, b, rand_alu_op(), next_rand(), next_rand(), 1'b0);
            end else begin
                run_pair(rand_alu_op(), next_rand(), next_rand(), op, a, b, 1'b0);
            end
            read_hilo();
        end
        end_test(name);
    endtask

    task automatic test_mt();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        x = next_rand();
        y = next_rand();
        z = next_rand();
        run_pair(OP_MTHI, x, '0, OP_MTLO, y, '0, 1'b0);
        read_hilo();
        run_pair(OP_MTHI, x, '0, OP_MTHI, y, '0, 1'b0);
        read_hilo();
        run_pair(OP_MTLO, y, '0, OP_MTLO, z, '0, 1'b0);
        read_hilo();
        run_pair(OP_MFHI, '0, '0, OP_MTHI, z, '0, 1'b0);
        read_hilo();
        run_pair(OP_MFLO, '0, '0, OP_MTLO, x, '0, 1'b0);
        read_hilo();
        end_test("mthi/mtlo");
    endtask

    task automatic test_flush();
        run_pair(OP_MTHI, next_rand(), '0, OP_MTLO, next_rand(), '0, 1'b1);
        read_hilo();
        run_pair(OP_NOP, '0, '0, OP_MADD, next_rand(), next_rand(), 1'b1);
        read_hilo();
        // abort a divide part way through
        @(posedge clk);
        req1_i      <= '{OP_DIV, next_rand(), 32'd7};
        req2_i      <= '0;
        flush_exc_i <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_val("stall_o", stall_o, 1'b1);
        end
        @(posedge clk);
        flush_i <= 1'b1;
        @(negedge clk);
        check_val("stall_o", stall_o, 1'b0);
        @(posedge clk);
        flush_i <= 1'b0;
        req1_i  <= '0;
        read_hilo();
        run_pair(OP_DIV, next_rand(), 32'hffff_fff9, OP_NOP, '0, '0, 1'b0);
        read_hilo();
        end_test("flush");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        flush_exc_i = 1'b0;
        req1_i      = '0;
        req2_i      = '0;
        lcg_q       = 32'd56708;
        model_hilo  = '0;
        check_count = 0;
        err_count   = 0;
        test_errs   = 0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        test_alu();
        test_md("multiply", 1'b0, 60);
        test_md("divide", 1'b1, 30);
        test_mt();
        test_flush();
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/alu_op_pkg.sv
common/exec_pkg.sv
rtl/alu_lane.sv
muldiv/mul_pipe.sv
muldiv/div_iter.sv
muldiv/muldiv_ctrl.sv
rtl/dual_exec.sv
sim/dual_exec_checker.sv
sim/dual_exec_tb.sv
